//--- Makefile
# Verilator build and run for the CSR unit testbench

SIM = obj_dir/csr_unit_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f all.f --top-module csr_unit_tb -o csr_unit_sim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+include
source/csr_pkg.sv
source/csr_access.sv
source/trap_arbiter.sv
source/csr_state.sv
source/csr_unit_top.sv
verification/csr_unit_tb.sv

//--- include/csr_defines.svh
/* CSR bit positions
   Field offsets inside mstatus and mie/mip, and the misa value */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// mstatus interrupt enable stack
`define MST_MIE  3
`define MST_MPIE 7

// Shared bit layout of mie and mip
`define MIX_MSI  3
`define MIX_MTI  7
`define MIX_MEI  11

// RV32I, MXL = 1
`define MISA_VALUE 32'h4000_0100

`endif

//--- source/csr_access.sv
/* CSR access
   Decodes the CSR address, muxes the read value and builds the masked write value */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_access #(
  parameter logic [csr_pkg::XLEN-1:0] HART_ID = '0
) (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  csr_pkg::csr_op_e         csr_op_i,
  input  logic [11:0]              csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0] rs1_data_i,
  input  logic [csr_pkg::XLEN-1:0] imm_i,
  input  logic                     rs1_is_x0_i,
  input  logic                     stall_i,
  input  logic [csr_pkg::XLEN-1:0] mstatus_i,
  input  logic [csr_pkg::XLEN-1:0] mie_i,
  input  logic [csr_pkg::XLEN-1:0] mtvec_i,
  input  logic [csr_pkg::XLEN-1:0] mscratch_i,
  input  logic [csr_pkg::XLEN-1:0] mepc_i,
  input  logic [csr_pkg::XLEN-1:0] mcause_i,
  input  logic [csr_pkg::XLEN-1:0] mtval_i,
  input  logic [csr_pkg::XLEN-1:0] mip_i,
  input  logic [63:0]              cycle_i,
  output logic [csr_pkg::XLEN-1:0] csr_rd_o,
  output csr_pkg::csr_sel_e        wr_sel_o,
  output logic [csr_pkg::XLEN-1:0] wr_data_o
);

  // Writable bits per register
  localparam logic [csr_pkg::XLEN-1:0] MASK_MSTATUS = 32'h807F_F9BB;
  localparam logic [csr_pkg::XLEN-1:0] MASK_MIE     = 32'h0000_0888;
  localparam logic [csr_pkg::XLEN-1:0] MASK_MTVEC   = 32'hFFFF_FFFD;
  localparam logic [csr_pkg::XLEN-1:0] MASK_MEPC    = 32'hFFFF_FFFC;
  localparam logic [csr_pkg::XLEN-1:0] MASK_MIP     = 32'h0000_0008;

  logic [csr_pkg::XLEN-1:0] wr_mask;
  logic [csr_pkg::XLEN-1:0] operand;
  logic [csr_pkg::XLEN-1:0] new_val;
  csr_pkg::csr_sel_e        target_sel;
  logic                     set_clr_op;
  logic                     do_write;

  // Read mux, write target and mask share one decode
  always_comb begin
    csr_rd_o   = '0;
    target_sel = csr_pkg::SEL_NONE;
    wr_mask    = '1;
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS: begin
        csr_rd_o   = mstatus_i;
        target_sel = csr_pkg::SEL_MSTATUS;
        wr_mask    = MASK_MSTATUS;
      end
      csr_pkg::CSR_MIE: begin
        csr_rd_o   = mie_i;
        target_sel = csr_pkg::SEL_MIE;
        wr_mask    = MASK_MIE;
      end
      csr_pkg::CSR_MTVEC: begin
        csr_rd_o   = mtvec_i;
        target_sel = csr_pkg::SEL_MTVEC;
        wr_mask    = MASK_MTVEC;
      end
      csr_pkg::CSR_MSCRATCH: begin
        csr_rd_o   = mscratch_i;
        target_sel = csr_pkg::SEL_MSCRATCH;
      end
      csr_pkg::CSR_MEPC: begin
        csr_rd_o   = mepc_i;
        target_sel = csr_pkg::SEL_MEPC;
        wr_mask    = MASK_MEPC;
      end
      csr_pkg::CSR_MTVAL: begin
        csr_rd_o   = mtval_i;
        target_sel = csr_pkg::SEL_MTVAL;
      end
      csr_pkg::CSR_MIP: begin
        csr_rd_o   = mip_i;
        target_sel = csr_pkg::SEL_MIP;
        wr_mask    = MASK_MIP;
      end
      // Read-only registers keep target_sel at none
      csr_pkg::CSR_MCAUSE:  csr_rd_o = mcause_i;
      csr_pkg::CSR_CYCLE:   csr_rd_o = cycle_i[31:0];
      csr_pkg::CSR_CYCLEH:  csr_rd_o = cycle_i[63:32];
      csr_pkg::CSR_MISA:    csr_rd_o = `MISA_VALUE;
      csr_pkg::CSR_MHARTID: csr_rd_o = HART_ID;
      default:              csr_rd_o = '0;
    endcase
  end

  // Zicsr operation on the old value
  always_comb begin
    operand = rs1_data_i;
    if (csr_op_i inside {csr_pkg::CSR_OP_RWI, csr_pkg::CSR_OP_RSI, csr_pkg::CSR_OP_RCI}) begin
      operand = imm_i;
    end
    case (csr_op_i)
      csr_pkg::CSR_OP_RW, csr_pkg::CSR_OP_RWI: new_val = operand;
      csr_pkg::CSR_OP_RS, csr_pkg::CSR_OP_RSI: new_val = csr_rd_o | operand;
      csr_pkg::CSR_OP_RC, csr_pkg::CSR_OP_RCI: new_val = csr_rd_o & ~operand;
      default:                                 new_val = csr_rd_o;
    endcase
    set_clr_op = csr_op_i inside {csr_pkg::CSR_OP_RS, csr_pkg::CSR_OP_RC,
                                  csr_pkg::CSR_OP_RSI, csr_pkg::CSR_OP_RCI};
    // Set/clear with x0 is a pure read
    do_write = (csr_op_i != csr_pkg::CSR_OP_NONE) && !stall_i &&
               !(set_clr_op && rs1_is_x0_i);
  end

  assign wr_sel_o  = do_write ? target_sel : csr_pkg::SEL_NONE;
  assign wr_data_o = new_val & wr_mask;

  // No register update may come from a stalled access
  a_no_write_on_stall: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    stall_i |-> (wr_sel_o == csr_pkg::SEL_NONE)
  ) else $error("csr_access: write target selected while stalled");

endmodule

//--- source/csr_pkg.sv
/* CSR unit package
   CSR addresses, Zicsr opcodes, write targets, trap causes and reset values */
package csr_pkg;

  // Data width of the core
  localparam int XLEN = 32;

  // mstatus after reset, MPP held at machine mode
  localparam logic [XLEN-1:0] MSTATUS_RESET = 32'h0000_1880;

  // Supported CSR addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MTVAL    = 12'h343,
    CSR_MIP      = 12'h344,
    CSR_CYCLE    = 12'hC00,
    CSR_CYCLEH   = 12'hC80,
    CSR_MHARTID  = 12'hF14
  } csr_addr_e;

  // Zicsr operations, encoded as funct3
  typedef enum logic [2:0] {
    CSR_OP_NONE = 3'b000,
    CSR_OP_RW   = 3'b001,
    CSR_OP_RS   = 3'b010,
    CSR_OP_RC   = 3'b011,
    CSR_OP_RWI  = 3'b101,
    CSR_OP_RSI  = 3'b110,
    CSR_OP_RCI  = 3'b111
  } csr_op_e;

  // Writable register targeted by a software write
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_MSTATUS,
    SEL_MIE,
    SEL_MTVEC,
    SEL_MSCRATCH,
    SEL_MEPC,
    SEL_MTVAL,
    SEL_MIP
  } csr_sel_e;

  // mcause codes, bit 31 marks an interrupt
  typedef enum logic [31:0] {
    CAUSE_IRQ_SW       = 32'h8000_0003,
    CAUSE_IRQ_TIMER    = 32'h8000_0007,
    CAUSE_IRQ_EXT      = 32'h8000_000B,
    CAUSE_MISALIGNED   = 32'h0000_0000,
    CAUSE_FETCH_FAULT  = 32'h0000_0001,
    CAUSE_ILLEGAL      = 32'h0000_0002,
    CAUSE_EBREAK       = 32'h0000_0003,
    CAUSE_LOAD_FAULT   = 32'h0000_0005,
    CAUSE_STORE_FAULT  = 32'h0000_0007,
    CAUSE_ECALL        = 32'h0000_000B
  } trap_cause_e;

endpackage

//--- source/csr_state.sv
/* CSR state
   Machine-mode registers, cycle counter, trap updates and the registered redirect */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_state #(
  parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_1000
) (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  csr_pkg::csr_sel_e        wr_sel_i,
  input  logic [csr_pkg::XLEN-1:0] wr_data_i,
  input  logic                     take_i,
  input  logic                     mret_i,
  input  csr_pkg::trap_cause_e     cause_i,
  input  logic [csr_pkg::XLEN-1:0] epc_i,
  input  logic [csr_pkg::XLEN-1:0] mtval_i,
  output logic [csr_pkg::XLEN-1:0] mstatus_o,
  output logic [csr_pkg::XLEN-1:0] mie_o,
  output logic [csr_pkg::XLEN-1:0] mtvec_o,
  output logic [csr_pkg::XLEN-1:0] mscratch_o,
  output logic [csr_pkg::XLEN-1:0] mepc_o,
  output logic [csr_pkg::XLEN-1:0] mcause_o,
  output logic [csr_pkg::XLEN-1:0] mtval_o,
  output logic [csr_pkg::XLEN-1:0] mip_o,
  output logic [63:0]              cycle_o,
  output logic                     mst_mie_o,
  output logic                     trap_valid_o,
  output logic [csr_pkg::XLEN-1:0] trap_pc_o
);

  logic [csr_pkg::XLEN-1:0] mstatus_d, mie_d, mtvec_d, mscratch_d;
  logic [csr_pkg::XLEN-1:0] mepc_d, mcause_d, mtval_d, mip_d;
  logic [csr_pkg::XLEN-1:0] vec_off;
  logic [csr_pkg::XLEN-1:0] trap_target;

  assign mst_mie_o = mstatus_o[`MST_MIE];

  // Software write first, trap update on top of it
  always_comb begin
    mstatus_d  = mstatus_o;
    mie_d      = mie_o;
    mtvec_d    = mtvec_o;
    mscratch_d = mscratch_o;
    mepc_d     = mepc_o;
    mcause_d   = mcause_o;
    mtval_d    = mtval_o;
    mip_d      = mip_o;
    case (wr_sel_i)
      csr_pkg::SEL_MSTATUS:  mstatus_d  = wr_data_i;
      csr_pkg::SEL_MIE:      mie_d      = wr_data_i;
      csr_pkg::SEL_MTVEC:    mtvec_d    = wr_data_i;
      csr_pkg::SEL_MSCRATCH: mscratch_d = wr_data_i;
      csr_pkg::SEL_MEPC:     mepc_d     = wr_data_i;
      csr_pkg::SEL_MTVAL:    mtval_d    = wr_data_i;
      csr_pkg::SEL_MIP:      mip_d      = wr_data_i;
      default: ;
    endcase
    if (take_i && !mret_i) begin
      mepc_d   = epc_i;
      mcause_d = cause_i;
      mtval_d  = mtval_i;
      case (cause_i)
        csr_pkg::CAUSE_IRQ_SW:    mip_d[`MIX_MSI] = 1'b1;
        csr_pkg::CAUSE_IRQ_TIMER: mip_d[`MIX_MTI] = 1'b1;
        csr_pkg::CAUSE_IRQ_EXT:   mip_d[`MIX_MEI] = 1'b1;
        default: ;
      endcase
      // Push the interrupt enable
      mstatus_d[`MST_MPIE] = mstatus_o[`MST_MIE];
      mstatus_d[`MST_MIE]  = 1'b0;
    end
    if (mret_i) begin
      mstatus_d[`MST_MIE]  = mstatus_o[`MST_MPIE];
      mstatus_d[`MST_MPIE] = 1'b1;
    end
  end

  // Redirect target, vectored offsets only for interrupts
  always_comb begin
    vec_off = '0;
    if (mtvec_o[0] && cause_i[31]) begin
      case (cause_i)
        csr_pkg::CAUSE_IRQ_SW:    vec_off = 32'h0C;
        csr_pkg::CAUSE_IRQ_TIMER: vec_off = 32'h1C;
        csr_pkg::CAUSE_IRQ_EXT:   vec_off = 32'h2C;
        default:                  vec_off = '0;
      endcase
    end
    trap_target = mret_i ? mepc_o : ({mtvec_o[31:2], 2'b00} + vec_off);
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mstatus_o    <= csr_pkg::MSTATUS_RESET;
      mie_o        <= '0;
      mtvec_o      <= MTVEC_RESET;
      mscratch_o   <= '0;
      mepc_o       <= '0;
      mcause_o     <= '0;
      mtval_o      <= '0;
      mip_o        <= '0;
      cycle_o      <= '0;
      trap_valid_o <= 1'b0;
    end else begin
      mstatus_o    <= mstatus_d;
      mie_o        <= mie_d;
      mtvec_o      <= mtvec_d;
      mscratch_o   <= mscratch_d;
      mepc_o       <= mepc_d;
      mcause_o     <= mcause_d;
      mtval_o      <= mtval_d;
      mip_o        <= mip_d;
      cycle_o      <= cycle_o + 64'd1;
      trap_valid_o <= take_i;
    end
  end

  // Redirect target captured with each taken trap
  always_ff @(posedge clk) begin
    if (take_i) begin
      trap_pc_o <= trap_target;
    end
  end

  // Trap enable clears MIE, so a redirect never repeats back to back
  a_valid_pulse: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    $rose(trap_valid_o) |=> !trap_valid_o
  ) else $error("csr_state: trap_valid_o held longer than one cycle");

endmodule

//--- source/csr_unit_top.sv
/* CSR unit top
   Connects CSR access, trap arbitration and the register state */
`timescale 1ns/1ps

module csr_unit_top #(
  parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_1000,
  parameter logic [csr_pkg::XLEN-1:0] HART_ID     = '0
) (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  csr_pkg::csr_op_e         csr_op_i,
  input  logic [11:0]              csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0] rs1_data_i,
  input  logic [csr_pkg::XLEN-1:0] imm_i,
  input  logic                     rs1_is_x0_i,
  input  logic                     stall_i,
  input  logic [csr_pkg::XLEN-1:0] pc_i,
  input  logic                     irq_ext_i,
  input  logic                     irq_sw_i,
  input  logic                     irq_timer_i,
  input  logic                     fetch_fault_i,
  input  logic [csr_pkg::XLEN-1:0] fetch_mtval_i,
  input  logic                     illegal_i,
  input  logic [csr_pkg::XLEN-1:0] illegal_pc_i,
  input  logic [csr_pkg::XLEN-1:0] illegal_mtval_i,
  input  logic                     jump_i,
  input  logic                     misaligned_i,
  input  logic [csr_pkg::XLEN-1:0] misaligned_mtval_i,
  input  logic                     ecall_i,
  input  logic                     ebreak_i,
  input  logic                     mret_i,
  input  logic                     store_fault_i,
  input  logic                     load_fault_i,
  output logic [csr_pkg::XLEN-1:0] csr_rd_o,
  output logic                     trap_valid_o,
  output logic [csr_pkg::XLEN-1:0] trap_pc_o
);

  // Register state fed back to the decoders
  logic [csr_pkg::XLEN-1:0] mstatus, mie, mtvec, mscratch;
  logic [csr_pkg::XLEN-1:0] mepc, mcause, mtval, mip;
  logic [63:0]              cycle;
  logic                     mst_mie;

  // Software write path
  csr_pkg::csr_sel_e        wr_sel;
  logic [csr_pkg::XLEN-1:0] wr_data;

  // Trap path
  logic                     take;
  logic                     mret;
  csr_pkg::trap_cause_e     cause;
  logic [csr_pkg::XLEN-1:0] epc;
  logic [csr_pkg::XLEN-1:0] trap_mtval;

  csr_access #(
    .HART_ID(HART_ID)
  ) u_access (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .csr_op_i(csr_op_i),
    .csr_addr_i(csr_addr_i),
    .rs1_data_i(rs1_data_i),
    .imm_i(imm_i),
    .rs1_is_x0_i(rs1_is_x0_i),
    .stall_i(stall_i),
    .mstatus_i(mstatus),
    .mie_i(mie),
    .mtvec_i(mtvec),
    .mscratch_i(mscratch),
    .mepc_i(mepc),
    .mcause_i(mcause),
    .mtval_i(mtval),
    .mip_i(mip),
    .cycle_i(cycle),
    .csr_rd_o(csr_rd_o),
    .wr_sel_o(wr_sel),
    .wr_data_o(wr_data)
  );

  trap_arbiter u_arbiter (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .pc_i(pc_i),
    .mst_mie_i(mst_mie),
    .mie_i(mie),
    .irq_ext_i(irq_ext_i),
    .irq_sw_i(irq_sw_i),
    .irq_timer_i(irq_timer_i),
    .fetch_fault_i(fetch_fault_i),
    .fetch_mtval_i(fetch_mtval_i),
    .illegal_i(illegal_i),
    .illegal_pc_i(illegal_pc_i),
    .illegal_mtval_i(illegal_mtval_i),
    .jump_i(jump_i),
    .misaligned_i(misaligned_i),
    .misaligned_mtval_i(misaligned_mtval_i),
    .ecall_i(ecall_i),
    .ebreak_i(ebreak_i),
    .mret_i(mret_i),
    .store_fault_i(store_fault_i),
    .load_fault_i(load_fault_i),
    .take_o(take),
    .mret_o(mret),
    .cause_o(cause),
    .epc_o(epc),
    .mtval_o(trap_mtval)
  );

  csr_state #(
    .MTVEC_RESET(MTVEC_RESET)
  ) u_state (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .wr_sel_i(wr_sel),
    .wr_data_i(wr_data),
    .take_i(take),
    .mret_i(mret),
    .cause_i(cause),
    .epc_i(epc),
    .mtval_i(trap_mtval),
    .mstatus_o(mstatus),
    .mie_o(mie),
    .mtvec_o(mtvec),
    .mscratch_o(mscratch),
    .mepc_o(mepc),
    .mcause_o(mcause),
    .mtval_o(mtval),
    .mip_o(mip),
    .cycle_o(cycle),
    .mst_mie_o(mst_mie),
    .trap_valid_o(trap_valid_o),
    .trap_pc_o(trap_pc_o)
  );

endmodule

//--- source/trap_arbiter.sv
/* Trap arbiter
   Fixed-priority selection among interrupts, exceptions and mret */
`timescale 1ns/1ps
`include "csr_defines.svh"

module trap_arbiter (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic [csr_pkg::XLEN-1:0] pc_i,
  input  logic                     mst_mie_i,
  input  logic [csr_pkg::XLEN-1:0] mie_i,
  input  logic                     irq_ext_i,
  input  logic                     irq_sw_i,
  input  logic                     irq_timer_i,
  input  logic                     fetch_fault_i,
  input  logic [csr_pkg::XLEN-1:0] fetch_mtval_i,
  input  logic                     illegal_i,
  input  logic [csr_pkg::XLEN-1:0] illegal_pc_i,
  input  logic [csr_pkg::XLEN-1:0] illegal_mtval_i,
  input  logic                     jump_i,
  input  logic                     misaligned_i,
  input  logic [csr_pkg::XLEN-1:0] misaligned_mtval_i,
  input  logic                     ecall_i,
  input  logic                     ebreak_i,
  input  logic                     mret_i,
  input  logic                     store_fault_i,
  input  logic                     load_fault_i,
  output logic                     take_o,
  output logic                     mret_o,
  output csr_pkg::trap_cause_e     cause_o,
  output logic [csr_pkg::XLEN-1:0] epc_o,
  output logic [csr_pkg::XLEN-1:0] mtval_o
);

  logic ext_en;
  logic sw_en;
  logic timer_en;

  // Interrupt needs global and per-source enable
  assign ext_en   = irq_ext_i   && mst_mie_i && mie_i[`MIX_MEI];
  assign sw_en    = irq_sw_i    && mst_mie_i && mie_i[`MIX_MSI];
  assign timer_en = irq_timer_i && mst_mie_i && mie_i[`MIX_MTI];

  always_comb begin
    take_o  = 1'b1;
    mret_o  = 1'b0;
    cause_o = csr_pkg::CAUSE_MISALIGNED;
    epc_o   = pc_i;
    mtval_o = '0;
    if (ext_en) begin
      cause_o = csr_pkg::CAUSE_IRQ_EXT;
    end else if (sw_en) begin
      cause_o = csr_pkg::CAUSE_IRQ_SW;
    end else if (timer_en) begin
      cause_o = csr_pkg::CAUSE_IRQ_TIMER;
    end else if (fetch_fault_i) begin
      cause_o = csr_pkg::CAUSE_FETCH_FAULT;
      mtval_o = fetch_mtval_i;
    end else if (illegal_i && !jump_i) begin
      // Decoded instruction is squashed when a jump is taken
      cause_o = csr_pkg::CAUSE_ILLEGAL;
      epc_o   = illegal_pc_i;
      mtval_o = illegal_mtval_i;
    end else if (misaligned_i) begin
      cause_o = csr_pkg::CAUSE_MISALIGNED;
      mtval_o = misaligned_mtval_i;
    end else if (ecall_i) begin
      cause_o = csr_pkg::CAUSE_ECALL;
    end else if (ebreak_i) begin
      cause_o = csr_pkg::CAUSE_EBREAK;
    end else if (mret_i) begin
      // Return rides the trap path, no cause update
      mret_o = 1'b1;
    end else if (store_fault_i) begin
      cause_o = csr_pkg::CAUSE_STORE_FAULT;
    end else if (load_fault_i) begin
      cause_o = csr_pkg::CAUSE_LOAD_FAULT;
    end else begin
      take_o = 1'b0;
    end
  end

  // A return is only ever issued as a taken redirect
  a_mret_takes: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    mret_o |-> take_o
  ) else $error("trap_arbiter: mret without take");

endmodule

//--- verification/csr_unit_tb.sv
/* CSR unit testbench
   Directed tests for CSR access, the cycle counter, traps and mret */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_unit_tb;

  localparam logic [31:0] MTVEC_RESET = 32'h0000_1000;
  localparam logic [31:0] HART_ID     = 32'h0000_0003;
  localparam int          TIMEOUT     = 20;

  // Writable bits per register
  localparam logic [31:0] MASK_MSTATUS = 32'h807F_F9BB;
  localparam logic [31:0] MASK_MIE     = 32'h0000_0888;
  localparam logic [31:0] MASK_MEPC    = 32'hFFFF_FFFC;

  logic clk;
  logic arst_n_i;
  csr_pkg::csr_op_e csr_op_i;
  logic [11:0] csr_addr_i;
  logic [31:0] rs1_data_i, imm_i, pc_i;
  logic rs1_is_x0_i, stall_i;
  logic irq_ext_i, irq_sw_i, irq_timer_i;
  logic fetch_fault_i, illegal_i, jump_i, misaligned_i;
  logic [31:0] fetch_mtval_i, illegal_pc_i, illegal_mtval_i, misaligned_mtval_i;
  logic ecall_i, ebreak_i, mret_i, store_fault_i, load_fault_i;
  logic [31:0] csr_rd_o;
  logic trap_valid_o;
  logic [31:0] trap_pc_o;

  integer seed;
  int errors;
  int tests_run;
  int tests_failed;

  csr_unit_top #(
    .MTVEC_RESET(MTVEC_RESET),
    .HART_ID(HART_ID)
  ) u_dut (
    .clk(clk), .arst_n_i(arst_n_i),
    .csr_op_i(csr_op_i), .csr_addr_i(csr_addr_i),
    .rs1_data_i(rs1_data_i), .imm_i(imm_i),
    .rs1_is_x0_i(rs1_is_x0_i), .stall_i(stall_i), .pc_i(pc_i),
    .irq_ext_i(irq_ext_i), .irq_sw_i(irq_sw_i), .irq_timer_i(irq_timer_i),
    .fetch_fault_i(fetch_fault_i), .fetch_mtval_i(fetch_mtval_i),
    .illegal_i(illegal_i), .illegal_pc_i(illegal_pc_i),
    .illegal_mtval_i(illegal_mtval_i), .jump_i(jump_i),
    .misaligned_i(misaligned_i), .misaligned_mtval_i(misaligned_mtval_i),
    .ecall_i(ecall_i), .ebreak_i(ebreak_i), .mret_i(mret_i),
    .store_fault_i(store_fault_i), .load_fault_i(load_fault_i),
    .csr_rd_o(csr_rd_o), .trap_valid_o(trap_valid_o), .trap_pc_o(trap_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d error(s)", name, errors - start_errors);
    end
  endtask

  task automatic clear_events();
    irq_ext_i          = 1'b0;
    irq_sw_i           = 1'b0;
    irq_timer_i        = 1'b0;
    fetch_fault_i      = 1'b0;
    fetch_mtval_i      = '0;
    illegal_i          = 1'b0;
    illegal_pc_i       = '0;
    illegal_mtval_i    = '0;
    jump_i             = 1'b0;
    misaligned_i       = 1'b0;
    misaligned_mtval_i = '0;
    ecall_i            = 1'b0;
    ebreak_i           = 1'b0;
    mret_i             = 1'b0;
    store_fault_i      = 1'b0;
    load_fault_i       = 1'b0;
  endtask

  // Pure read, one cycle per call
  task automatic read_csr(input csr_pkg::csr_addr_e addr, output logic [31:0] val);
    @(negedge clk);
    csr_op_i   = csr_pkg::CSR_OP_NONE;
    csr_addr_i = addr;
    #1;
    val = csr_rd_o;
  endtask

  // One access for one cycle, returns the value read during it
  task automatic issue_access(input csr_pkg::csr_op_e op, input csr_pkg::csr_addr_e addr,
                              input logic [31:0] rs1, input logic [31:0] imm,
                              input logic x0, input logic stall, output logic [31:0] old);
    @(negedge clk);
    csr_op_i    = op;
    csr_addr_i  = addr;
    rs1_data_i  = rs1;
    imm_i       = imm;
    rs1_is_x0_i = x0;
    stall_i     = stall;
    #1;
    old = csr_rd_o;
    @(negedge clk);
    csr_op_i    = csr_pkg::CSR_OP_NONE;
    rs1_is_x0_i = 1'b0;
    stall_i     = 1'b0;
  endtask

  // Zicsr rule before the register mask
  function automatic logic [31:0] apply_op(input csr_pkg::csr_op_e op, input logic [31:0] old,
                                           input logic [31:0] rs1, input logic [31:0] imm);
    case (op)
      csr_pkg::CSR_OP_RW:  return rs1;
      csr_pkg::CSR_OP_RS:  return old | rs1;
      csr_pkg::CSR_OP_RC:  return old & ~rs1;
      csr_pkg::CSR_OP_RWI: return imm;
      csr_pkg::CSR_OP_RSI: return old | imm;
      csr_pkg::CSR_OP_RCI: return old & ~imm;
      default:             return old;
    endcase
  endfunction

  task automatic wait_trap(input string name, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < TIMEOUT) begin
      if (trap_valid_o) begin
        seen = 1'b1;
      end else begin
        @(negedge clk);
        n++;
      end
    end
    if (!seen) begin
      $display("%s: no trap redirect within %0d cycles", name, TIMEOUT);
      errors++;
    end
  endtask

  // Events are driven by the caller on the current falling edge
  task automatic expect_trap(input string name, input logic [31:0] cause,
                             input logic [31:0] epc, input logic [31:0] tval,
                             input logic [31:0] target, input logic old_mie);
    bit seen;
    logic [31:0] v;
    @(negedge clk);
    clear_events();
    wait_trap(name, seen);
    if (seen) begin
      check({name, " trap_pc_o"}, trap_pc_o, target);
      read_csr(csr_pkg::CSR_MCAUSE, v);
      check({name, " mcause"}, v, cause);
      read_csr(csr_pkg::CSR_MEPC, v);
      check({name, " mepc"}, v, epc);
      read_csr(csr_pkg::CSR_MTVAL, v);
      check({name, " mtval"}, v, tval);
      read_csr(csr_pkg::CSR_MSTATUS, v);
      check({name, " mstatus.MIE"}, 32'(v[`MST_MIE]), 32'd0);
      check({name, " mstatus.MPIE"}, 32'(v[`MST_MPIE]), 32'(old_mie));
    end
  endtask

  task automatic expect_no_trap(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (trap_valid_o) begin
        $display("%s: trap redirect raised although it should be masked", name);
        errors++;
      end
    end
    clear_events();
  endtask

  task automatic test_reset();
    logic [31:0] v;
    int start;
    start = errors;
    check("trap_valid_o", 32'(trap_valid_o), 32'd0);
    read_csr(csr_pkg::CSR_MSTATUS, v);
    check("mstatus", v, csr_pkg::MSTATUS_RESET);
    read_csr(csr_pkg::CSR_MTVEC, v);
    check("mtvec", v, MTVEC_RESET);
    read_csr(csr_pkg::CSR_MISA, v);
    check("misa", v, `MISA_VALUE);
    read_csr(csr_pkg::CSR_MHARTID, v);
    check("mhartid", v, HART_ID);
    read_csr(csr_pkg::CSR_MIE, v);
    check("mie", v, 32'd0);
    read_csr(csr_pkg::CSR_MSCRATCH, v);
    check("mscratch", v, 32'd0);
    read_csr(csr_pkg::CSR_MEPC, v);
    check("mepc", v, 32'd0);
    read_csr(csr_pkg::CSR_MCAUSE, v);
    check("mcause", v, 32'd0);
    read_csr(csr_pkg::CSR_MTVAL, v);
    check("mtval", v, 32'd0);
    read_csr(csr_pkg::CSR_MIP, v);
    check("mip", v, 32'd0);
    report_test("reset values", start);
  endtask

  task automatic test_csr_ops();
    csr_pkg::csr_addr_e addrs[4];
    csr_pkg::csr_op_e ops[6];
    logic [31:0] masks[4];
    logic [31:0] model[4];
    logic [31:0] rs1, imm, old, v;
    int r, k, start;
    start = errors;
    addrs = '{csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MIE, csr_pkg::CSR_MEPC, csr_pkg::CSR_MSTATUS};
    masks = '{32'hFFFF_FFFF, MASK_MIE, MASK_MEPC, MASK_MSTATUS};
    model = '{32'd0, 32'd0, 32'd0, csr_pkg::MSTATUS_RESET};
    ops = '{csr_pkg::CSR_OP_RW, csr_pkg::CSR_OP_RS, csr_pkg::CSR_OP_RC,
            csr_pkg::CSR_OP_RWI, csr_pkg::CSR_OP_RSI, csr_pkg::CSR_OP_RCI};
    for (r = 0; r < 4; r++) begin
      for (k = 0; k < 6; k++) begin
        rs1 = $random(seed);
        imm = $random(seed);
        issue_access(ops[k], addrs[r], rs1, imm, 1'b0, 1'b0, old);
        check($sformatf("csr %h read during %s", addrs[r], ops[k].name()), old, model[r]);
        model[r] = apply_op(ops[k], model[r], rs1, imm) & masks[r];
        read_csr(addrs[r], v);
        check($sformatf("csr %h after %s", addrs[r], ops[k].name()), v, model[r]);
      end
    end
    // Set with x0 and a stalled write leave mscratch alone
    issue_access(csr_pkg::CSR_OP_RS, csr_pkg::CSR_MSCRATCH, 32'hFFFF_FFFF, '0, 1'b1, 1'b0, old);
    read_csr(csr_pkg::CSR_MSCRATCH, v);
    check("mscratch after set with x0", v, model[0]);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSCRATCH, $random(seed), '0, 1'b0, 1'b1, old);
    read_csr(csr_pkg::CSR_MSCRATCH, v);
    check("mscratch after stalled write", v, model[0]);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MCAUSE, $random(seed), '0, 1'b0, 1'b0, old);
    read_csr(csr_pkg::CSR_MCAUSE, v);
    check("mcause after write", v, 32'd0);
    report_test("csr operations", start);
  endtask

  task automatic test_cycle();
    logic [31:0] c0, c1;
    int start;
    start = errors;
    @(negedge clk);
    csr_op_i   = csr_pkg::CSR_OP_NONE;
    csr_addr_i = csr_pkg::CSR_CYCLE;
    #1;
    c0 = csr_rd_o;
    repeat (10) @(negedge clk);
    #1;
    c1 = csr_rd_o;
    check("cycle difference", c1 - c0, 32'd10);
    read_csr(csr_pkg::CSR_CYCLEH, c1);
    check("cycleh", c1, 32'd0);
    report_test("cycle counter", start);
  endtask

  task automatic test_exceptions();
    logic [31:0] old, tval;
    int start;
    start = errors;
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSTATUS, 32'h0000_1808, '0, 1'b0, 1'b0, old);
    tval = $random(seed);
    @(negedge clk);
    pc_i = 32'h0000_2000;
    illegal_i = 1'b1;
    illegal_pc_i = 32'h0000_1FFC;
    illegal_mtval_i = tval;
    ecall_i = 1'b1;
    ebreak_i = 1'b1;
    load_fault_i = 1'b1;
    expect_trap("illegal", csr_pkg::CAUSE_ILLEGAL, 32'h0000_1FFC, tval, 32'h0000_1000, 1'b1);
    // Squashed by a taken jump
    @(negedge clk);
    illegal_i = 1'b1;
    jump_i = 1'b1;
    expect_no_trap("squashed illegal", 3);
    // MIE stays clear from here on, so each trap pushes 0 into MPIE
    @(negedge clk);
    illegal_i = 1'b1;
    jump_i = 1'b1;
    ecall_i = 1'b1;
    ebreak_i = 1'b1;
    expect_trap("ecall", csr_pkg::CAUSE_ECALL, pc_i, 32'd0, 32'h0000_1000, 1'b0);
    tval = $random(seed);
    @(negedge clk);
    pc_i = 32'h0000_2040;
    fetch_fault_i = 1'b1;
    fetch_mtval_i = tval;
    misaligned_i = 1'b1;
    store_fault_i = 1'b1;
    expect_trap("fetch fault", csr_pkg::CAUSE_FETCH_FAULT, 32'h0000_2040, tval,
                32'h0000_1000, 1'b0);
    tval = $random(seed);
    @(negedge clk);
    misaligned_i = 1'b1;
    misaligned_mtval_i = tval;
    ebreak_i = 1'b1;
    load_fault_i = 1'b1;
    expect_trap("misaligned", csr_pkg::CAUSE_MISALIGNED, pc_i, tval, 32'h0000_1000, 1'b0);
    @(negedge clk);
    store_fault_i = 1'b1;
    load_fault_i = 1'b1;
    expect_trap("store fault", csr_pkg::CAUSE_STORE_FAULT, pc_i, 32'd0, 32'h0000_1000, 1'b0);
    report_test("exceptions", start);
  endtask

  task automatic test_interrupts();
    logic [31:0] old, v;
    int start;
    start = errors;
    // MIE is clear after the last exception
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MIE, 32'h0000_0888, '0, 1'b0, 1'b0, old);
    @(negedge clk);
    irq_ext_i = 1'b1;
    expect_no_trap("external with MIE clear", 3);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSTATUS, 32'h0000_1808, '0, 1'b0, 1'b0, old);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MIE, 32'd0, '0, 1'b0, 1'b0, old);
    @(negedge clk);
    irq_ext_i = 1'b1;
    irq_sw_i = 1'b1;
    irq_timer_i = 1'b1;
    expect_no_trap("interrupts with mie clear", 3);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MIE, 32'h0000_0888, '0, 1'b0, 1'b0, old);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MTVEC, 32'h0000_2001, '0, 1'b0, 1'b0, old);
    @(negedge clk);
    pc_i = 32'h0000_3000;
    irq_ext_i = 1'b1;
    irq_sw_i = 1'b1;
    irq_timer_i = 1'b1;
    expect_trap("external irq", csr_pkg::CAUSE_IRQ_EXT, 32'h0000_3000, 32'd0, 32'h0000_202C,
                1'b1);
    read_csr(csr_pkg::CSR_MIP, v);
    check("mip.MEI", 32'(v[`MIX_MEI]), 32'd1);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSTATUS, 32'h0000_1808, '0, 1'b0, 1'b0, old);
    @(negedge clk);
    irq_sw_i = 1'b1;
    irq_timer_i = 1'b1;
    expect_trap("software irq", csr_pkg::CAUSE_IRQ_SW, 32'h0000_3000, 32'd0, 32'h0000_200C,
                1'b1);
    read_csr(csr_pkg::CSR_MIP, v);
    check("mip.MSI", 32'(v[`MIX_MSI]), 32'd1);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSTATUS, 32'h0000_1808, '0, 1'b0, 1'b0, old);
    @(negedge clk);
    irq_timer_i = 1'b1;
    expect_trap("timer irq", csr_pkg::CAUSE_IRQ_TIMER, 32'h0000_3000, 32'd0, 32'h0000_201C,
                1'b1);
    read_csr(csr_pkg::CSR_MIP, v);
    check("mip.MTI", 32'(v[`MIX_MTI]), 32'd1);
    report_test("interrupts", start);
  endtask

  // mret driven by the caller on the current falling edge
  task automatic expect_return(input string name, input logic [31:0] epc,
                               input logic old_mpie, input logic [31:0] cause);
    bit seen;
    logic [31:0] v;
    @(negedge clk);
    clear_events();
    wait_trap(name, seen);
    if (seen) begin
      check({name, " trap_pc_o"}, trap_pc_o, epc);
      read_csr(csr_pkg::CSR_MSTATUS, v);
      check({name, " mstatus.MIE"}, 32'(v[`MST_MIE]), 32'(old_mpie));
      check({name, " mstatus.MPIE"}, 32'(v[`MST_MPIE]), 32'd1);
      read_csr(csr_pkg::CSR_MCAUSE, v);
      check({name, " mcause"}, v, cause);
    end
  endtask

  task automatic test_mret();
    logic [31:0] ep, old;
    int start;
    start = errors;
    // Last trap was the timer interrupt at 0x3000, taken with MIE set
    @(negedge clk);
    mret_i = 1'b1;
    expect_return("mret after trap", 32'h0000_3000, 1'b1, csr_pkg::CAUSE_IRQ_TIMER);
    // Return to a software-written mepc with MPIE clear
    ep = $random(seed);
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MEPC, ep, '0, 1'b0, 1'b0, old);
    ep = ep & MASK_MEPC;
    issue_access(csr_pkg::CSR_OP_RW, csr_pkg::CSR_MSTATUS, 32'h0000_1800, '0, 1'b0, 1'b0, old);
    @(negedge clk);
    mret_i = 1'b1;
    expect_return("mret to written mepc", ep, 1'b0, csr_pkg::CAUSE_IRQ_TIMER);
    report_test("mret", start);
  endtask

  initial begin
    seed         = 97;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    arst_n_i     = 1'b0;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
    csr_addr_i   = '0;
    rs1_data_i   = '0;
    imm_i        = '0;
    rs1_is_x0_i  = 1'b0;
    stall_i      = 1'b0;
    pc_i         = '0;
    clear_events();
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    test_reset();
    test_csr_ops();
    test_cycle();
    test_exceptions();
    test_interrupts();
    test_mret();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
